// ==== Makefile ====
TOP = tb_extmem_fifo
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > $(LOG)
	cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== extmem_fifo_ctrl.sv ====
`timescale 1ns/1ps

module extmem_fifo_ctrl (
	input  logic                    clk,
	input  logic                    reset,

	input  logic                    in_valid,
	input  extmem_fifo_pkg::data_t  in_data,
	output logic                    in_ready,

	output logic                    out_valid,
	output extmem_fifo_pkg::data_t  out_data,
	input  logic                    out_ready,

	output extmem_fifo_pkg::level_t fill,

	extmem_if.controller            mem
);

	typedef enum logic [1:0] {
		st_idle,
		st_writing,
		st_reading
	} state_t;

	state_t state;

	// Circular pointers into the memory
	extmem_fifo_pkg::addr_t wr_ptr;
	extmem_fifo_pkg::addr_t rd_ptr;

	// Words currently stored in memory
	extmem_fifo_pkg::level_t count;

	// Registered memory request
	logic                   req_q;
	logic                   we_q;
	extmem_fifo_pkg::addr_t addr_q;
	extmem_fifo_pkg::data_t wdata_q;

	// Output register
	logic                   out_valid_q;
	extmem_fifo_pkg::data_t out_data_q;

	logic mem_full;
	logic mem_empty;
	logic start_read;
	logic start_write;
	logic write_done;
	logic read_done;
	logic pop_fire;

	assign mem_full  = (count == extmem_fifo_pkg::level_full);
	assign mem_empty = (count == '0);

	// Refill the output register first, so a waiting consumer is served
	// before new words go into memory
	assign start_read = (state == st_idle) && !out_valid_q && !mem_empty;

	// Push side only opens out of reset while idle with room and no read pending
	assign in_ready    = !reset && (state == st_idle) && !mem_full && !start_read;
	assign start_write = in_valid && in_ready;

	assign write_done = (state == st_writing) && mem.done;
	assign read_done  = (state == st_reading) && mem.done;

	assign pop_fire = out_valid_q && out_ready;

	// Sequencer, one memory access at a time
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			req_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (start_read) begin
						state <= st_reading;
						req_q <= 1'b1;
					end else if (start_write) begin
						state <= st_writing;
						req_q <= 1'b1;
					end
				end
				st_writing,
				st_reading: begin
					// Drop the request right after completion
					if (mem.done) begin
						state <= st_idle;
						req_q <= 1'b0;
					end
				end
				default: begin
					state <= st_idle;
					req_q <= 1'b0;
				end
			endcase
		end
	end

	// Request payload is loaded together with req and held until done
	always_ff @(posedge clk) begin
		if (start_read) begin
			we_q   <= 1'b0;
			addr_q <= rd_ptr;
		end else if (start_write) begin
			we_q    <= 1'b1;
			addr_q  <= wr_ptr;
			wdata_q <= in_data;
		end
	end

	// Write pointer moves once the word is really in memory
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
		end else if (write_done) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Read pointer moves as soon as the read is issued
	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
		end else if (start_read) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Fill count
	// write_done and start_read never fall in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (write_done) begin
			count <= count + 1'b1;
		end else if (start_read) begin
			count <= count - 1'b1;
		end
	end

	// Output register valid flag
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid_q <= 1'b0;
		end else if (read_done) begin
			out_valid_q <= 1'b1;
		end else if (pop_fire) begin
			out_valid_q <= 1'b0;
		end
	end

	// Captured read word that stays put while the consumer stalls
	always_ff @(posedge clk) begin
		if (read_done) begin
			out_data_q <= mem.rdata;
		end
	end

	assign mem.req   = req_q;
	assign mem.we    = we_q;
	assign mem.addr  = addr_q;
	assign mem.wdata = wdata_q;

	assign out_valid = out_valid_q;
	assign out_data  = out_data_q;
	assign fill      = count;

endmodule

// ==== extmem_fifo_pkg.sv ====
package extmem_fifo_pkg;

	// Width of one stored word
	localparam int data_bits = 8;

	// Words held in the external memory
	// Kept a power of two so the pointers wrap on their own
	localparam int depth = 16;

	// Address width for depth words
	localparam int addr_bits = $clog2(depth);

	// Cycles from the first sampled request to the done pulse
	localparam int wait_cycles = 3;

	// Wait-state counter must hold values up to wait_cycles - 1
	localparam int wait_bits = $clog2(wait_cycles + 1);

	// One data word, as stored and as seen on the push and pop ports
	typedef logic [data_bits-1:0] data_t;

	// Memory word address
	typedef logic [addr_bits-1:0] addr_t;

	// Fill level, covers 0 up to and including depth
	typedef logic [addr_bits:0] level_t;

	// Wait-state down-counter inside the memory model
	typedef logic [wait_bits-1:0] wait_t;

	// Fill value at which the memory has no free word
	localparam level_t level_full = level_t'(depth);

endpackage

// ==== extmem_fifo_top.sv ====
`timescale 1ns/1ps

module extmem_fifo_top (
	input  logic                    clk,
	input  logic                    reset,

	// Push side
	input  logic                    in_valid,
	input  extmem_fifo_pkg::data_t  in_data,
	output logic                    in_ready,

	// Pop side
	output logic                    out_valid,
	output extmem_fifo_pkg::data_t  out_data,
	input  logic                    out_ready,

	// Words held in memory, not counting the output register
	output extmem_fifo_pkg::level_t fill
);

	extmem_if mem_if ();

	extmem_fifo_ctrl ctrl_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready),
		.fill      (fill),
		.mem       (mem_if.controller)
	);

	extmem_sram sram_inst (
		.clk   (clk),
		.reset (reset),
		.mem   (mem_if.memory)
	);

endmodule

// ==== extmem_if.sv ====
`timescale 1ns/1ps

// Single request channel between the FIFO controller and the memory
interface extmem_if;

	// Request side, held steady until done
	logic                   req;
	logic                   we;
	extmem_fifo_pkg::addr_t addr;
	extmem_fifo_pkg::data_t wdata;

	// Completion side, rdata is valid while done is high
	extmem_fifo_pkg::data_t rdata;
	logic                   done;

	modport controller (
		output req,
		output we,
		output addr,
		output wdata,
		input  rdata,
		input  done
	);

	modport memory (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output rdata,
		output done
	);

endinterface

// ==== extmem_sram.sv ====
`timescale 1ns/1ps

// Slow single-port memory with a fixed number of wait states
module extmem_sram (
	input  logic     clk,
	input  logic     reset,
	extmem_if.memory mem
);

	extmem_fifo_pkg::data_t mem_array [extmem_fifo_pkg::depth];

	// Wait-state counter and its run flag
	extmem_fifo_pkg::wait_t wait_count;
	logic                   busy;

	logic                   done_q;
	extmem_fifo_pkg::data_t rdata_q;

	logic start;
	logic expire;

	// A new access starts on a request that is not the tail of the last one
	// The controller still holds req in the cycle done is high
	assign start  = mem.req && !busy && !done_q;
	assign expire = busy && (wait_count == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy       <= 1'b0;
			wait_count <= '0;
			done_q     <= 1'b0;
		end else begin
			done_q <= expire;
			if (expire) begin
				busy <= 1'b0;
			end else if (busy) begin
				wait_count <= wait_count - 1'b1;
			end else if (start) begin
				busy       <= 1'b1;
				wait_count <= extmem_fifo_pkg::wait_t'(extmem_fifo_pkg::wait_cycles - 1);
			end
		end
	end

	// Array access happens on the last wait state
	// so rdata lines up with the done pulse
	always_ff @(posedge clk) begin
		if (expire) begin
			if (mem.we) begin
				mem_array[mem.addr] <= mem.wdata;
			end else begin
				rdata_q <= mem_array[mem.addr];
			end
		end
	end

	assign mem.done  = done_q;
	assign mem.rdata = rdata_q;

endmodule

// ==== src.f ====
extmem_fifo_pkg.sv
extmem_if.sv
extmem_fifo_ctrl.sv
extmem_sram.sv
extmem_fifo_top.sv
tb_extmem_fifo.sv

// ==== tb_extmem_fifo.sv ====
`timescale 1ns/1ps

module tb_extmem_fifo;

	// Cycles any single wait may take before it counts as stuck
	localparam int step_limit = 200;

	logic                    clk;
	logic                    reset;
	logic                    in_valid;
	extmem_fifo_pkg::data_t  in_data;
	logic                    in_ready;
	logic                    out_valid;
	extmem_fifo_pkg::data_t  out_data;
	logic                    out_ready;
	extmem_fifo_pkg::level_t fill;

	integer seed;
	int     error_count;
	int     tests_passed;
	int     tests_failed;
	int     test_start_errors;

	// Words pushed but not yet popped with the oldest first
	extmem_fifo_pkg::data_t ref_q [$];

	extmem_fifo_top extmem_fifo_top_inst (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready),
		.fill      (fill)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic check_data(input extmem_fifo_pkg::data_t expected,
			input extmem_fifo_pkg::data_t actual, input string name);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_level(input extmem_fifo_pkg::level_t expected,
			input extmem_fifo_pkg::level_t actual, input string name);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input logic expected, input logic actual, input string name);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s expected %b, got %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		error_count++;
	endtask

	task automatic start_test;
		test_start_errors = error_count;
	endtask

	task automatic end_test(input string name);
		if (error_count == test_start_errors) begin
			$display("Test %s: passed", name);
			tests_passed++;
		end else begin
			$display("Test %s: failed with %0d errors", name, error_count - test_start_errors);
			tests_failed++;
		end
	endtask

	// Called just after a falling edge, returns just after a falling edge
	task automatic push_word(input extmem_fifo_pkg::data_t d);
		int waited;
		waited = 0;
		while (!in_ready && waited < step_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!in_ready) begin
			report_timeout("in_ready");
		end else begin
			in_valid = 1'b1;
			in_data  = d;
			ref_q.push_back(d);
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	// Waits for a word, checks it against the oldest pushed word, pops it
	task automatic pop_word;
		int                     waited;
		extmem_fifo_pkg::data_t expected;
		waited    = 0;
		out_ready = 1'b1;
		while (!out_valid && waited < step_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!out_valid) begin
			report_timeout("out_valid");
		end else if (ref_q.size() == 0) begin
			$display("Word %h popped at %0t ns with nothing pushed", out_data, $time);
			error_count++;
			@(negedge clk);
		end else begin
			expected = ref_q.pop_front();
			check_data(expected, out_data, "out_data");
			@(negedge clk);
		end
	endtask

	task automatic test_reset;
		start_test();
		check_flag(1'b0, out_valid, "out_valid");
		check_level('0, fill, "fill");
		end_test("reset");
	endtask

	task automatic test_single;
		start_test();
		push_word(extmem_fifo_pkg::data_t'($random(seed)));
		pop_word();
		out_ready = 1'b0;
		end_test("single word");
	endtask

	task automatic test_stream;
		start_test();
		out_ready = 1'b1;
		fork
			begin
				for (int i = 0; i < 40; i++) begin
					push_word(extmem_fifo_pkg::data_t'($random(seed)));
				end
			end
			begin
				for (int j = 0; j < 40; j++) begin
					pop_word();
				end
			end
		join
		out_ready = 1'b0;
		end_test("streaming order");
	endtask

	task automatic test_fill_full;
		int accepted;
		int idle;
		int cycles;
		start_test();
		out_ready = 1'b0;
		accepted  = 0;
		idle      = 0;
		cycles    = 0;
		// Offer a word on every cycle until in_ready has been low for 20 cycles
		while (idle < 20 && cycles < 1000) begin
			if (in_ready) begin
				in_valid = 1'b1;
				in_data  = extmem_fifo_pkg::data_t'($random(seed));
				ref_q.push_back(in_data);
				accepted++;
				idle = 0;
			end else begin
				in_valid = 1'b0;
				idle++;
			end
			@(negedge clk);
			cycles++;
		end
		in_valid = 1'b0;
		if (idle < 20) begin
			report_timeout("in_ready to stay low");
		end
		if (accepted != extmem_fifo_pkg::depth + 1) begin
			$display("[FAIL] %0t ns: accepted words expected %0d, got %0d",
				$time, extmem_fifo_pkg::depth + 1, accepted);
			error_count++;
		end
		check_level(extmem_fifo_pkg::level_t'(extmem_fifo_pkg::depth), fill, "fill");
		end_test("fill to full");
	endtask

	task automatic test_drain;
		int words;
		start_test();
		words = ref_q.size();
		repeat (words) begin
			pop_word();
		end
		repeat (10) begin
			check_flag(1'b0, out_valid, "out_valid after drain");
			@(negedge clk);
		end
		out_ready = 1'b0;
		check_level('0, fill, "fill");
		end_test("drain");
	endtask

	task automatic test_stall;
		int                     waited;
		extmem_fifo_pkg::data_t held;
		start_test();
		out_ready = 1'b0;
		repeat (3) begin
			push_word(extmem_fifo_pkg::data_t'($random(seed)));
		end
		waited = 0;
		while (!out_valid && waited < step_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!out_valid) begin
			report_timeout("out_valid before the stall");
		end else begin
			held = out_data;
			repeat (6) begin
				@(negedge clk);
				check_flag(1'b1, out_valid, "out_valid during stall");
				check_data(held, out_data, "out_data during stall");
			end
		end
		repeat (3) begin
			pop_word();
		end
		out_ready = 1'b0;
		end_test("stalled output");
	endtask

	initial begin
		seed         = 32'hc1a9;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		reset        = 1'b1;
		in_valid     = 1'b0;
		in_data      = '0;
		out_ready    = 1'b0;

		repeat (4) @(negedge clk);
		reset = 1'b0;

		test_reset();
		test_single();
		test_stream();
		test_fill_full();
		test_drain();
		test_stall();

		$display("Tests passed: %0d, tests failed: %0d, errors: %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
